//--- filelist.f
rtl/sink_pkg.sv
rtl/mem_store_if.sv
rtl/sink_cfg_regs.sv
rtl/sink_addrgen.sv
rtl/sink_addr_fifo.sv
rtl/sink_store_unit.sv
rtl/sink_top.sv
tests/sink_checker.sv
tests/sink_tb.sv

//--- rtl/mem_store_if.sv
//////////////////////////////////////////////////
// memory write port
// req/gnt store request toward the TCDM
//////////////////////////////////////////////////

`timescale 1ns/100ps

interface mem_store_if;

  import sink_pkg::*;

  logic               req;  // held until gnt
  logic [addr_w-1:0]  add;  // word aligned byte address
  logic [mem_w/8-1:0] be;
  logic [mem_w-1:0]   data;
  logic               gnt;  // req & gnt = one store done

  modport initiator (
    output req,
    output add,
    output be,
    output data,
    input  gnt
  );

  modport target (
    input  req,
    input  add,
    input  be,
    input  data,
    output gnt
  );

endinterface

//--- rtl/sink_addr_fifo.sv
//////////////////////////////////////////////////
// sink address FIFO
// two-entry first-word-fall-through ring between
// the address generator and the store unit
//////////////////////////////////////////////////

`timescale 1ns/100ps

module sink_addr_fifo (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        push_valid_i,
  output logic                        push_ready_o,
  input  logic [sink_pkg::addr_w-1:0] push_data_i,
  output logic                        pop_valid_o,
  input  logic                        pop_ready_i,
  output logic [sink_pkg::addr_w-1:0] pop_data_o
);

  import sink_pkg::*;

  logic [addr_w-1:0] mem_q [2]; // entries
  logic              wr_ptr_q;
  logic              rd_ptr_q;
  logic [1:0]        count_q;   // 0, 1 or 2
  logic              push;
  logic              pop;

  assign push_ready_o = (count_q != 2'd2);
  assign pop_valid_o  = (count_q != 2'd0);
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= 1'b0; // end of transfer, drop everything
      rd_ptr_q <= 1'b0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop)  rd_ptr_q <= ~rd_ptr_q;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ; // both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  assign pop_data_o = mem_q[rd_ptr_q]; // head shows without a pop

endmodule

//--- rtl/sink_addrgen.sv
//////////////////////////////////////////////////
// sink address generator
// offers base + n * stride for n = 0 .. len-1,
// one per accepted cycle, flags done on the last
//////////////////////////////////////////////////

`timescale 1ns/100ps

module sink_addrgen (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        start_i,
  input  logic [sink_pkg::addr_w-1:0] base_i,
  input  logic [sink_pkg::addr_w-1:0] stride_i,
  input  logic [sink_pkg::cnt_w-1:0]  len_i,
  output logic                        addr_valid_o,
  input  logic                        addr_ready_i,
  output logic [sink_pkg::addr_w-1:0] addr_o,
  output logic                        done_o
);

  import sink_pkg::*;

  logic [addr_w-1:0] addr_q;   // running address
  logic [addr_w-1:0] stride_q;
  logic [cnt_w-1:0]  len_q;
  logic [cnt_w-1:0]  cnt_q;    // addresses issued so far
  logic              active_q;
  logic              empty_q;  // zero-length run, done straight away
  logic              accept;
  logic              last;

  assign accept = active_q & addr_ready_i;
  assign last   = (cnt_q == len_q - 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      empty_q  <= 1'b0;
      cnt_q    <= '0;
    end else if (start_i) begin
      active_q <= (len_i != '0);
      empty_q  <= (len_i == '0);
      cnt_q    <= '0;
    end else begin
      empty_q <= 1'b0; // one cycle only
      if (accept) begin
        cnt_q <= cnt_q + 1'b1;
        if (last) begin
          active_q <= 1'b0; // stop after the final address
        end
      end
    end
  end

  // sampled config and running address, no reset needed
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q   <= base_i;
      stride_q <= stride_i;
      len_q    <= len_i;
    end else if (accept) begin
      addr_q <= addr_q + stride_q;
    end
  end

  assign addr_valid_o = active_q;
  assign addr_o       = addr_q;
  // high in the cycle the last address is taken
  assign done_o       = (accept & last) | empty_q;

endmodule

//--- rtl/sink_cfg_regs.sv
//////////////////////////////////////////////////
// sink configuration registers
// base, stride and length words, start strobe
// and busy tracking with combinational readback
//////////////////////////////////////////////////

`timescale 1ns/100ps

module sink_cfg_regs (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        cfg_we_i,
  input  logic [1:0]                  cfg_addr_i,
  input  logic [31:0]                 cfg_wdata_i,
  output logic [31:0]                 cfg_rdata_o,
  input  logic                        done_i,
  output logic [sink_pkg::addr_w-1:0] base_o,
  output logic [sink_pkg::addr_w-1:0] stride_o,
  output logic [sink_pkg::cnt_w-1:0]  len_o,
  output logic                        start_o,
  output logic                        busy_o
);

  import sink_pkg::*;

  logic [addr_w-1:0] base_q;
  logic [addr_w-1:0] stride_q;
  logic [cnt_w-1:0]  len_q;
  logic              busy_q;
  logic              cfg_wr; // config word write, only while not busy

  assign cfg_wr  = cfg_we_i & ~busy_q;
  // start is bit 0 of the control word, dropped while a run is active
  assign start_o = cfg_wr & (cfg_addr_i == reg_ctrl) & cfg_wdata_i[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q   <= '0;
      stride_q <= '0;
      len_q    <= '0;
    end else if (cfg_wr) begin
      case (cfg_addr_i)
        reg_base:   base_q   <= cfg_wdata_i;
        reg_stride: stride_q <= cfg_wdata_i;
        reg_len:    len_q    <= cfg_wdata_i[cnt_w-1:0]; // upper bits dropped
        default:    ; // ctrl has no storage
      endcase
    end
  end

  // busy from the edge after start until the edge after done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (start_o) begin
      busy_q <= 1'b1;
    end else if (done_i) begin
      busy_q <= 1'b0;
    end
  end

  always_comb begin
    case (cfg_addr_i)
      reg_base:   cfg_rdata_o = base_q;
      reg_stride: cfg_rdata_o = stride_q;
      reg_len:    cfg_rdata_o = {{(32-cnt_w){1'b0}}, len_q};
      default:    cfg_rdata_o = {31'd0, busy_q}; // status
    endcase
  end

  assign base_o   = base_q;
  assign stride_o = stride_q;
  assign len_o    = len_q;
  assign busy_o   = busy_q;

endmodule

//--- rtl/sink_pkg.sv
//////////////////////////////////////////////////
// sink streamer package
// widths, register map, FSM states and the
// two-view address word shared by the store path
//////////////////////////////////////////////////

package sink_pkg;

  localparam int unsigned addr_w   = 32;           // byte address
  localparam int unsigned stream_w = 32;           // engine stream beat
  localparam int unsigned mem_w    = stream_w + 32; // room for any byte offset
  localparam int unsigned cnt_w    = 16;           // transfer counter

  // register offsets, word granular
  localparam logic [1:0] reg_base   = 2'd0;
  localparam logic [1:0] reg_stride = 2'd1;
  localparam logic [1:0] reg_len    = 2'd2;
  localparam logic [1:0] reg_ctrl   = 2'd3;

  typedef enum logic [1:0] {
    idle     = 2'd0,
    working  = 2'd1, // addresses still being generated
    draining = 2'd2  // last stores completing
  } sink_state_e;

  // one address word, seen as a byte address or split into word and lane offset
  typedef union packed {
    logic [addr_w-1:0] byte_addr;
    struct packed {
      logic [addr_w-3:0] word_idx;
      logic [1:0]        offset;
    } fields;
  } sink_addr_u;

endpackage

//--- rtl/sink_store_unit.sv
//////////////////////////////////////////////////
// sink store unit
// pairs each queued address with one stream beat,
// aligns data and strobes into the 64-bit lane
// and issues req/gnt stores until len are done
//////////////////////////////////////////////////

`timescale 1ns/100ps

module sink_store_unit (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            start_i,
  input  logic [sink_pkg::cnt_w-1:0]      len_i,
  input  logic                            agen_done_i,
  input  logic                            addr_valid_i,
  output logic                            addr_ready_o,
  input  logic [sink_pkg::addr_w-1:0]     addr_i,
  input  logic                            stream_valid_i,
  output logic                            stream_ready_o,
  input  logic [sink_pkg::stream_w-1:0]   stream_data_i,
  input  logic [sink_pkg::stream_w/8-1:0] stream_strb_i,
  mem_store_if.initiator                  mem,
  output logic                            done_o
);

  import sink_pkg::*;

  sink_state_e state_q;
  sink_state_e state_d;
  logic        finish;      // draining -> idle this cycle
  logic        done_q;
  logic        active;      // any state but idle
  logic        store_fire;  // req & gnt

  logic [cnt_w-1:0]      store_cnt_q;
  sink_addr_u            head_addr;   // FIFO head, two views
  logic [mem_w-1:0]      data_wide;
  logic [mem_w/8-1:0]    strb_wide;
  logic [mem_w-1:0]      data_aligned;
  logic [mem_w/8-1:0]    strb_aligned;

  assign active = (state_q != idle);

  always_comb begin
    state_d = state_q;
    finish  = 1'b0;
    case (state_q)
      idle: begin
        if (start_i) state_d = working;
      end
      working: begin
        if (agen_done_i) state_d = draining; // all addresses queued
      end
      draining: begin
        if (store_cnt_q == len_i) begin
          state_d = idle;
          finish  = 1'b1;
        end
      end
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= idle;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= finish; // one-cycle pulse after the last store
    end
  end

  // completed stores, counted against len
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      store_cnt_q <= '0;
    end else if (finish) begin
      store_cnt_q <= '0;
    end else if (store_fire) begin
      store_cnt_q <= store_cnt_q + 1'b1;
    end
  end

  // byte lane alignment
  assign head_addr.byte_addr = addr_i;
  assign data_wide    = {{(mem_w-stream_w){1'b0}}, stream_data_i};
  assign strb_wide    = {{((mem_w-stream_w)/8){1'b0}}, stream_strb_i};
  // offset 1..3 pushes the beat up into the upper half
  assign data_aligned = data_wide << {head_addr.fields.offset, 3'b000};
  assign strb_aligned = strb_wide << head_addr.fields.offset;

  // memory port, all fields quiet in idle
  assign mem.req  = active & stream_valid_i & addr_valid_i;
  assign mem.add  = active ? {head_addr.fields.word_idx, 2'b00} : '0;
  assign mem.be   = active ? strb_aligned : '0;
  assign mem.data = active ? data_aligned : '0;

  assign store_fire = mem.req & mem.gnt;

  // beat and address leave together on a granted store
  assign stream_ready_o = active & (~stream_valid_i | (mem.gnt & addr_valid_i));
  assign addr_ready_o   = stream_valid_i & stream_ready_o;

  assign done_o = done_q;

endmodule

//--- rtl/sink_top.sv
//////////////////////////////////////////////////
// sink streamer top
// config registers, address generator, address
// FIFO and store unit behind plain ports
//////////////////////////////////////////////////

`timescale 1ns/100ps

module sink_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // configuration
  input  logic                            cfg_we_i,
  input  logic [1:0]                      cfg_addr_i,
  input  logic [31:0]                     cfg_wdata_i,
  output logic [31:0]                     cfg_rdata_o,
  // engine stream
  input  logic                            stream_valid_i,
  output logic                            stream_ready_o,
  input  logic [sink_pkg::stream_w-1:0]   stream_data_i,
  input  logic [sink_pkg::stream_w/8-1:0] stream_strb_i,
  // memory store port
  output logic                            mem_req_o,
  input  logic                            mem_gnt_i,
  output logic [sink_pkg::addr_w-1:0]     mem_add_o,
  output logic [sink_pkg::mem_w/8-1:0]    mem_be_o,
  output logic [sink_pkg::mem_w-1:0]      mem_data_o,
  // status
  output logic                            busy_o,
  output logic                            done_o
);

  import sink_pkg::*;

  logic [addr_w-1:0] base;
  logic [addr_w-1:0] stride;
  logic [cnt_w-1:0]  len;
  logic              start;
  logic              done;
  logic              agen_done;
  logic              agen_valid;  // generator -> FIFO
  logic              agen_ready;
  logic [addr_w-1:0] agen_addr;
  logic              head_valid;  // FIFO -> store unit
  logic              head_ready;
  logic [addr_w-1:0] head_addr;

  mem_store_if mem_bus ();

  sink_cfg_regs u_cfg_regs (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .done_i      ( done        ),
    .base_o      ( base        ),
    .stride_o    ( stride      ),
    .len_o       ( len         ),
    .start_o     ( start       ),
    .busy_o      ( busy_o      )
  );

  sink_addrgen u_addrgen (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .start_i      ( start      ),
    .base_i       ( base       ),
    .stride_i     ( stride     ),
    .len_i        ( len        ),
    .addr_valid_o ( agen_valid ),
    .addr_ready_i ( agen_ready ),
    .addr_o       ( agen_addr  ),
    .done_o       ( agen_done  )
  );

  sink_addr_fifo u_addr_fifo (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( done       ), // flushed at end of run
    .push_valid_i ( agen_valid ),
    .push_ready_o ( agen_ready ),
    .push_data_i  ( agen_addr  ),
    .pop_valid_o  ( head_valid ),
    .pop_ready_i  ( head_ready ),
    .pop_data_o   ( head_addr  )
  );

  sink_store_unit u_store_unit (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .start_i        ( start          ),
    .len_i          ( len            ),
    .agen_done_i    ( agen_done      ),
    .addr_valid_i   ( head_valid     ),
    .addr_ready_o   ( head_ready     ),
    .addr_i         ( head_addr      ),
    .stream_valid_i ( stream_valid_i ),
    .stream_ready_o ( stream_ready_o ),
    .stream_data_i  ( stream_data_i  ),
    .stream_strb_i  ( stream_strb_i  ),
    .mem            ( mem_bus        ),
    .done_o         ( done           )
  );

  // interface out to plain memory ports
  assign mem_req_o   = mem_bus.req;
  assign mem_add_o   = mem_bus.add;
  assign mem_be_o    = mem_bus.be;
  assign mem_data_o  = mem_bus.data;
  assign mem_bus.gnt = mem_gnt_i;

  assign done_o = done;

endmodule

//--- tests/sink_checker.sv
//////////////////////////////////////////////////
// sink store unit checker
// concurrent checks on the memory request, the
// stream handshake and the done pulse
//////////////////////////////////////////////////

`timescale 1ns/100ps

module sink_checker (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic [1:0]                    state_i,
  input logic                          req_i,
  input logic                          gnt_i,
  input logic [sink_pkg::addr_w-1:0]   add_i,
  input logic [sink_pkg::mem_w/8-1:0]  be_i,
  input logic [sink_pkg::mem_w-1:0]    data_i,
  input logic                          stream_valid_i,
  input logic                          stream_ready_i,
  input logic                          done_i
);

  import sink_pkg::*;

  int unsigned fail_count = 0; // failed assertions so far

  // waiting request keeps every field until granted
  req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !gnt_i |=> req_i && $stable(add_i) && $stable(be_i) && $stable(data_i))
    else begin
      fail_count++;
      $error("memory request dropped or changed before its grant");
    end

  done_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i) // one cycle wide
    else begin
      fail_count++;
      $error("done held for more than one cycle");
    end

  idle_quiet_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i == idle |-> !req_i)
    else begin
      fail_count++;
      $error("memory request raised in idle");
    end

  // an offered beat stays up until the store takes it
  beat_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stream_valid_i && !stream_ready_i |=> stream_valid_i)
    else begin
      fail_count++;
      $error("stream beat withdrawn before it was accepted");
    end

endmodule

bind sink_store_unit sink_checker u_checker (
  .clk_i          ( clk_i          ),
  .rst_ni         ( rst_ni         ),
  .state_i        ( state_q        ),
  .req_i          ( mem.req        ),
  .gnt_i          ( mem.gnt        ),
  .add_i          ( mem.add        ),
  .be_i           ( mem.be         ),
  .data_i         ( mem.data       ),
  .stream_valid_i ( stream_valid_i ),
  .stream_ready_i ( stream_ready_o ),
  .done_i         ( done_o         )
);

//--- tests/sink_tb.sv
//////////////////////////////////////////////////
// sink streamer testbench
// programs runs, drives the stream and grants,
// models the memory and checks the final image
//////////////////////////////////////////////////

`timescale 1ns/100ps

module sink_tb;

  import sink_pkg::*;

  localparam int mem_bytes = 1024;

  logic        clk_i;
  logic        rst_ni;
  logic        cfg_we_i;
  logic [1:0]  cfg_addr_i;
  logic [31:0] cfg_wdata_i;
  logic [31:0] cfg_rdata_o;
  logic        stream_valid_i;
  logic        stream_ready_o;
  logic [31:0] stream_data_i;
  logic [3:0]  stream_strb_i;
  logic        mem_req_o;
  logic        mem_gnt_i;
  logic [31:0] mem_add_o;
  logic [7:0]  mem_be_o;
  logic [63:0] mem_data_o;
  logic        busy_o;
  logic        done_o;

  logic [7:0]  mem_model [mem_bytes];
  logic [7:0]  mem_snap [mem_bytes]; // image before the current run
  logic [31:0] beat_data [$];
  logic [3:0]  beat_strb [$];
  logic [31:0] run_base;
  logic [31:0] run_stride;
  int          run_len;
  int          store_count;
  int          check_count;
  int          error_count;
  logic [31:0] lfsr_q;
  sink_addr_u  store_addr;

  sink_top u_sink_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1
  endfunction

  // one step per bit handed out
  function automatic logic [31:0] random_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic [7:0] fill_byte(logic [9:0] a);
    return a[7:0] ^ {a[9:8], a[9:8], a[9:8], a[9:8]} ^ 8'ha5;
  endfunction

  // beat n at base + n*stride, strobed byte j at that address + j, later beats win
  function automatic logic [7:0] ref_byte(int unsigned a, logic [7:0] prior);
    logic [7:0]  r;
    logic [31:0] beat_addr;
    r = prior;
    for (int n = 0; n < run_len; n++) begin
      beat_addr = run_base + n * run_stride;
      for (int j = 0; j < 4; j++) begin
        if (beat_strb[n][j] && (beat_addr + j == a)) r = beat_data[n][8*j +: 8];
      end
    end
    return r;
  endfunction

  task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("[FAIL] %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic end_simulation();
    int unsigned assert_fails;
    assert_fails = u_sink_top.u_store_unit.u_checker.fail_count;
    $display("%0d checks, %0d errors, %0d assertion failures",
             check_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // all tasks below start and end 2 ns after a rising edge
  task automatic cfg_write(logic [1:0] addr, logic [31:0] data);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(posedge clk_i);
    #2 cfg_we_i = 1'b0;
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      @(posedge clk_i);
      check_eq("mem_req_o", mem_req_o, 0);
      check_eq("done_o", done_o, 0);
      #2;
    end
  endtask

  task automatic run_transfer(logic [31:0] base, logic [31:0] stride, int len,
                              bit rand_strb, bit stalls);
    int beat_idx;
    int cycles;
    bit took;
    bit done_seen;
    cfg_write(reg_base, base);
    cfg_write(reg_stride, stride);
    cfg_write(reg_len, len);
    @(posedge clk_i);
    check_eq("cfg_rdata_o", cfg_rdata_o, len); // length readback
    #2;
    run_base   = base;
    run_stride = stride;
    run_len    = len;
    beat_data.delete();
    beat_strb.delete();
    for (int n = 0; n < len; n++) begin
      beat_data.push_back(random_bits(32));
      beat_strb.push_back(rand_strb ? 4'(random_bits(4)) : 4'hf);
    end
    mem_snap    = mem_model;
    store_count = 0;
    cfg_write(reg_ctrl, 32'd1); // start, addr stays on status
    beat_idx  = 0;
    cycles    = 0;
    done_seen = 1'b0;
    while (!done_seen) begin
      @(posedge clk_i);
      took      = stream_valid_i && stream_ready_o;
      done_seen = done_o;
      if (took) beat_idx++;
      check_eq("busy_o", busy_o, 1);
      check_eq("cfg_rdata_o", cfg_rdata_o, 1);
      cycles++;
      if (cycles > 2000) begin
        error_count++;
        $display("timeout: done_o never came, %0d of %0d beats taken", beat_idx, len);
        end_simulation();
      end
      #2;
      cfg_we_i  = (cycles == 3); // second start while busy
      mem_gnt_i = stalls ? (random_bits(1) != 0) : 1'b1;
      if (!stream_valid_i || took) begin
        stream_valid_i = (beat_idx < len) && !(stalls && random_bits(2) == 2'b11);
        if (beat_idx < len) begin
          stream_data_i = beat_data[beat_idx];
          stream_strb_i = beat_strb[beat_idx];
        end
      end
    end
    check_eq("beats taken", beat_idx, len);
    cfg_we_i       = 1'b0;
    stream_valid_i = 1'b0;
    mem_gnt_i      = 1'b0;
    @(posedge clk_i);
    check_eq("busy_o", busy_o, 0); // falls after done
    check_eq("cfg_rdata_o", cfg_rdata_o, 0);
    #2;
    idle_cycles(3);
  endtask

  // byte-addressed memory behind the store port
  always @(posedge clk_i) begin : memory_write
    int idx;
    if (mem_req_o && mem_gnt_i) begin
      store_addr.byte_addr = mem_add_o;
      check_count++;
      assert (store_addr.fields.offset == 2'b00 && mem_add_o < mem_bytes - 8) else begin
        error_count++;
        $display("store address 0x%0h is unaligned or outside the model", mem_add_o);
      end
      for (int i = 0; i < 8; i++) begin
        idx = ({store_addr.fields.word_idx, 2'b00} + i) % mem_bytes;
        if (mem_be_o[i]) mem_model[idx] = mem_data_o[8*i +: 8];
      end
      store_count++;
    end
  end

  // whole image against the reference once done shows
  always @(posedge clk_i) begin : image_compare
    logic [7:0] exp_byte;
    if (rst_ni && done_o) begin
      for (int a = 0; a < mem_bytes; a++) begin
        exp_byte = ref_byte(a, mem_snap[a]);
        check_eq($sformatf("mem_model[0x%03h]", a), mem_model[a], exp_byte);
      end
      check_eq("store_count", store_count, run_len);
    end
  end

  initial begin
    rst_ni         = 1'b0;
    cfg_we_i       = 1'b0;
    cfg_addr_i     = '0;
    cfg_wdata_i    = '0;
    stream_valid_i = 1'b0;
    stream_data_i  = '0;
    stream_strb_i  = '0;
    mem_gnt_i      = 1'b0;
    lfsr_q         = 32'd95860;
    check_count    = 0;
    error_count    = 0;
    run_len        = 0;
    for (int a = 0; a < mem_bytes; a++) mem_model[a] = fill_byte(a);
    mem_snap = mem_model;
    repeat (8) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    @(posedge clk_i);
    check_eq("stream_ready_o", stream_ready_o, 0); // quiet out of reset
    check_eq("busy_o", busy_o, 0);
    #2;
    idle_cycles(2);
    run_transfer(32'h040, 32'd4, 8, 1'b0, 1'b0);  // aligned, full strobes
    run_transfer(32'h0a1, 32'd9, 6, 1'b0, 1'b0);  // offsets 1, 2, 3, 0
    run_transfer(32'h120, 32'd8, 8, 1'b1, 1'b0);  // partial strobes
    run_transfer(32'h203, 32'd5, 16, 1'b1, 1'b1); // stalls and gaps
    run_transfer(32'h302, 32'd3, 12, 1'b1, 1'b1); // overlapping beats
    end_simulation();
  end

endmodule
